// ==== act_unit_tests.txt ====
0 0 12345678 12345678
0 0 FF80007F FF80007F
0 0 A5C3E10F A5C3E10F
1 0 7F00FF80 7F000000
1 0 01FE4281 01004200
1 0 C0337FFF 00337F00
2 0 27595A7F 63637F7F
2 0 101B1C26 4263667A
2 0 FF00010F FC00043C
2 0 E4E5F0F1 9A9DBEC4
2 0 A6A7D9DA 819D9D86
2 0 1D285B80 68637F81
2 0 EFFE0211 BBF80845
2 0 64A5D8E3 7F819D98
0 5 11223344 11003300
1 A 7F80FF10 00000010
2 6 5A0FE480 7F000081
2 F 7F7F7F7F 00000000
0 F FFFFFFFF 00000000
1 1 40302010 40302000
2 8 101B1C26 0063667A
0 0 01010101 01010101
0 0 02020202 02020202
1 0 03FD03FD 03000300
2 0 04040404 10101010
0 3 05050505 05050000
2 0 FBFBFBFB ECECECEC

// ==== sources.f ====
act_data_pkg.sv
act_func_pkg.sv
act_row_feeder.sv
act_lane.sv
act_row_collector.sv
act_unit_top.sv
act_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the activation unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f sources.f --top-module act_unit_tb \
    --Mdir obj_dir -o act_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/act_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// ==== act_unit_tb.sv ====
`timescale 1ns/10ps

module act_unit_tb
    import act_data_pkg::*;
    import act_func_pkg::*;
();

    localparam int max_vecs = 64;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 in_req;
    logic                 in_ack;
    logic [row_width-1:0] in_data;
    act_op_t              in_op;
    logic [lanes-1:0]     in_mask;
    logic                 out_req;
    logic                 out_ack;
    logic [row_width-1:0] out_data;

    logic [1:0]           vec_op   [max_vecs];
    logic [lanes-1:0]     vec_mask [max_vecs];
    logic [row_width-1:0] vec_data [max_vecs];
    logic [row_width-1:0] vec_exp  [max_vecs];

    int         num_vecs = 0;
    int         rows_seen = 0;
    int         cycle_count = 0;
    int         timeout_cycles = 0;
    logic [7:0] lfsr_state = 8'd28;

    act_unit_top dut_i (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_data  (in_data),
        .in_op    (in_op),
        .in_mask  (in_mask),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // limit scales with the number of rows in the vector file
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
            abort_run($sformatf("timeout after %0d cycles, only %0d of %0d rows came out",
                                cycle_count, rows_seen, num_vecs));
        end
    end

    // everything is driven and sampled 1 ns after the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        logic fb;
        fb = s[7] ^ s[5] ^ s[4] ^ s[3];
        return {s[6:0], fb};
    endfunction

    // three bits, one step each, gives 0 to 7 cycles
    task automatic pick_ack_delay(output int cycles);
        logic [2:0] bits;
        bits = '0;
        for (int b = 0; b < 3; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[1:0], lfsr_state[0]};
        end
        cycles = int'(bits);
    endtask

    // columns: opcode, mask, input row, expected row
    task automatic read_vectors();
        int                   fd;
        int                   got;
        logic [1:0]           op_f;
        logic [lanes-1:0]     mask_f;
        logic [row_width-1:0] data_f;
        logic [row_width-1:0] exp_f;
        fd = $fopen("act_unit_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the vector file act_unit_tests.txt");
        end
        got = $fscanf(fd, "%h %h %h %h\n", op_f, mask_f, data_f, exp_f);
        while (got == 4 && num_vecs < max_vecs) begin
            vec_op[num_vecs]   = op_f;
            vec_mask[num_vecs] = mask_f;
            vec_data[num_vecs] = data_f;
            vec_exp[num_vecs]  = exp_f;
            num_vecs++;
            got = $fscanf(fd, "%h %h %h %h\n", op_f, mask_f, data_f, exp_f);
        end
        $fclose(fd);
        if (num_vecs == 0) begin
            abort_run("the vector file holds no usable rows");
        end
        timeout_cycles = num_vecs * 30 + 100;
    endtask

    // rows go back to back, next one right after ack falls
    task automatic send_rows();
        for (int i = 0; i < num_vecs; i++) begin
            in_data = vec_data[i];
            in_op   = act_op_t'(vec_op[i]);
            in_mask = vec_mask[i];
            in_req  = 1'b1;
            do wait_cycle(); while (!in_ack);
            in_req = 1'b0;
            do wait_cycle(); while (in_ack);
        end
    endtask

    task automatic receive_rows();
        int delay;
        for (int n = 0; n < num_vecs; n++) begin
            do wait_cycle(); while (!out_req);
            check_word($sformatf("out_data (row %0d)", n), out_data, vec_exp[n]);
            rows_seen++;
            pick_ack_delay(delay);
            repeat (delay) wait_cycle();
            out_ack = 1'b1;
            do wait_cycle(); while (out_req);
            out_ack = 1'b0;
        end
    endtask

    initial begin
        reset   = 1'b1;
        in_req  = 1'b0;
        in_data = '0;
        in_op   = act_bypass;
        in_mask = '0;
        out_ack = 1'b0;
        read_vectors();

        repeat (3) wait_cycle();
        reset = 1'b0;

        // idle after reset, nothing offered yet
        repeat (4) begin
            wait_cycle();
            check_word("in_ack", 32'(in_ack), 32'h0);
            check_word("out_req", 32'(out_req), 32'h0);
        end

        fork
            send_rows();
            receive_rows();
        join

        // no extra row may follow the last one
        repeat (10) begin
            wait_cycle();
            check_word("out_req", 32'(out_req), 32'h0);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== act_unit_top.sv ====
`timescale 1ns/10ps

module act_unit_top
    import act_data_pkg::*;
    import act_func_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_req,
    output logic                 in_ack,
    input  logic [row_width-1:0] in_data,
    input  act_op_t              in_op,
    input  logic [lanes-1:0]     in_mask,
    output logic                 out_req,
    input  logic                 out_ack,
    output logic [row_width-1:0] out_data
);

    logic                 issue;
    logic                 room;
    logic [row_width-1:0] row_data;
    act_op_t              row_op;
    logic [lanes-1:0]     row_mask;
    logic [lanes-1:0]     lane_valid;
    logic [row_width-1:0] lane_row;

    act_row_feeder feeder_i (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_data  (in_data),
        .in_op    (in_op),
        .in_mask  (in_mask),
        .room     (room),
        .issue    (issue),
        .row_data (row_data),
        .row_op   (row_op),
        .row_mask (row_mask)
    );

    // one lane per element, all share issue and opcode
    for (genvar g = 0; g < lanes; g++) begin : gen_lane
        act_lane lane_i (
            .clk        (clk),
            .reset      (reset),
            .issue      (issue),
            .x          (row_data[g*dwidth +: dwidth]),
            .op         (row_op),
            .mask       (row_mask[g]),
            .lane_valid (lane_valid[g]),
            .y          (lane_row[g*dwidth +: dwidth])
        );
    end

    // lanes run in lockstep, lane 0 speaks for the row
    act_row_collector collector_i (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .lane_valid (lane_valid[0]),
        .lane_row   (lane_row),
        .room       (room),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_data   (out_data)
    );

endmodule

// ==== act_row_collector.sv ====
`timescale 1ns/10ps

module act_row_collector
    import act_data_pkg::*;
    import act_func_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  logic                 lane_valid,
    input  logic [row_width-1:0] lane_row,
    output logic                 room,
    output logic                 out_req,
    input  logic                 out_ack,
    output logic [row_width-1:0] out_data
);

    hs_state_t state;
    logic      pending;
    logic      capture;

    // a row in the lanes already claims the holding register
    assign room = !pending && (state == hs_idle);

    assign capture = lane_valid && (state == hs_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= hs_idle;
            out_req <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (issue) begin
                pending <= 1'b1;
            end else if (lane_valid) begin
                pending <= 1'b0;
            end

            case (state)
                hs_idle: begin
                    if (capture) begin
                        out_req <= 1'b1;
                        state   <= hs_hold;
                    end
                end
                hs_hold: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= hs_release;
                    end
                end
                hs_release: begin
                    // register freed once the receiver drops ack
                    if (!out_ack) begin
                        state <= hs_idle;
                    end
                end
                default: state <= hs_idle;
            endcase
        end
    end

    // holding register, stable while out_req is high
    always_ff @(posedge clk) begin
        if (capture) begin
            out_data <= lane_row;
        end
    end

endmodule

// ==== act_lane.sv ====
`timescale 1ns/10ps

module act_lane
    import act_data_pkg::*;
    import act_func_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  logic [dwidth-1:0] x,
    input  act_op_t           op,
    input  logic              mask,
    output logic              lane_valid,
    output logic [dwidth-1:0] y
);

    logic signed [dwidth-1:0] xs;
    logic [3:0]               seg;
    logic [dwidth-1:0]        tanh_y;
    logic [dwidth-1:0]        relu_y;
    logic [dwidth-1:0]        act_y;
    logic [dwidth-1:0]        next_y;

    assign xs = $signed(x);

    // segment lookup against the signed lower bounds
    // bounds descend, so the lowest index that matches wins
    always_comb begin
        seg = 4'(tanh_segs - 1);
        for (int i = tanh_segs - 2; i >= 0; i--) begin
            if (xs >= tanh_lo[i]) begin
                seg = 4'(i);
            end
        end
    end

    // low 8 bits only, no saturation
    assign tanh_y = tanh_slope[seg] * x + tanh_icpt[seg];

    // negative values clamp to zero
    assign relu_y = x[dwidth-1] ? '0 : x;

    always_comb begin
        case (op)
            act_relu: act_y = relu_y;
            act_tanh: act_y = tanh_y;
            default:  act_y = x;
        endcase
    end

    // masked lane reads as zero whatever the opcode
    assign next_y = mask ? '0 : act_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= issue;
        end
    end

    // result only moves on issue, held otherwise
    always_ff @(posedge clk) begin
        if (issue) begin
            y <= next_y;
        end
    end

endmodule

// ==== act_row_feeder.sv ====
`timescale 1ns/10ps

module act_row_feeder
    import act_data_pkg::*;
    import act_func_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_req,
    output logic                 in_ack,
    input  logic [row_width-1:0] in_data,
    input  act_op_t              in_op,
    input  logic [lanes-1:0]     in_mask,
    input  logic                 room,
    output logic                 issue,
    output logic [row_width-1:0] row_data,
    output act_op_t              row_op,
    output logic [lanes-1:0]     row_mask
);

    hs_state_t state;
    logic      full;
    logic      take;

    // register free now, or freed by the issue in this same cycle
    assign take = in_req && (state != hs_release) && (!full || issue);

    // row goes to the lanes as soon as the collector can absorb it
    assign issue = full && room;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= hs_idle;
            in_ack <= 1'b0;
            full   <= 1'b0;
        end else begin
            case (state)
                hs_idle, hs_hold: begin
                    if (take) begin
                        in_ack <= 1'b1;
                        state  <= hs_release;
                    end else if (in_req) begin
                        // sender waits, ack held back until the row drains
                        state <= hs_hold;
                    end
                end
                hs_release: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= hs_idle;
                    end
                end
                default: state <= hs_idle;
            endcase

            if (take) begin
                full <= 1'b1;
            end else if (issue) begin
                full <= 1'b0;
            end
        end
    end

    // captured row, stable from capture through issue
    always_ff @(posedge clk) begin
        if (take) begin
            row_data <= in_data;
            row_op   <= in_op;
            row_mask <= in_mask;
        end
    end

endmodule

// ==== act_func_pkg.sv ====
package act_func_pkg;

    // activation selected per row
    typedef enum logic [1:0] {
        act_bypass = 2'd0,
        act_relu   = 2'd1,
        act_tanh   = 2'd2
    } act_op_t;

    // four-phase handshake states, shared by feeder and collector
    typedef enum logic [1:0] {
        hs_idle    = 2'd0,
        hs_hold    = 2'd1,
        hs_release = 2'd2
    } hs_state_t;

    // piecewise-linear tanh, y = slope * x + intercept
    localparam int tanh_segs = 11;

    // lower bound of each segment, highest segment first
    // last segment covers everything down to -128
    localparam logic signed [7:0] tanh_lo [tanh_segs] = '{
        8'sd90, 8'sd39, 8'sd28, 8'sd16, 8'sd1, 8'sd0,
        -8'sd15, -8'sd27, -8'sd38, -8'sd89, 8'sh80
    };

    localparam logic [7:0] tanh_slope [tanh_segs] = '{
        8'd0, 8'd0, 8'd2, 8'd3, 8'd4, 8'd0,
        8'd4, 8'd3, 8'd2, 8'd0, 8'd0
    };

    // saturating ends at +-127, zero around the origin
    localparam logic signed [7:0] tanh_icpt [tanh_segs] = '{
        8'sd127, 8'sd99, 8'sd46, 8'sd18, 8'sd0, 8'sd0,
        8'sd0, -8'sd18, -8'sd46, -8'sd99, -8'sd127
    };

endpackage

// ==== act_data_pkg.sv ====
package act_data_pkg;

    // element format coming out of the matrix multiplier
    localparam int dwidth = 8;

    // elements per row, one activation lane each
    localparam int lanes = 4;

    // packed row, element 0 in the low byte
    localparam int row_width = dwidth * lanes;

endpackage
